//--- files.f
hdl/mul_pkg.sv
hdl/register_file.sv
hdl/booth_multiplier.sv
hdl/mul_sequencer.sv
hdl/mul_core_top.sv
verif/mul_core_tb.sv

//--- Bender.yml
package:
  name: mul_core

sources:
  # shared package first
  - hdl/mul_pkg.sv
  - hdl/register_file.sv
  - hdl/booth_multiplier.sv
  - hdl/mul_sequencer.sv
  - hdl/mul_core_top.sv

  # testbench
  - target: test
    files:
      - verif/mul_core_tb.sv

//--- verif/mul_core_tb.sv
`timescale 1ns/1ps

module mul_core_tb;

	import mul_pkg::*;

	localparam int xlen = xlen_default;
	// a full multiply needs about 35 cycles
	localparam int ack_timeout = 200;

	logic      clk;
	logic      rst;
	logic      req;
	mul_cmd_t  cmd;
	logic      ack;
	mul_resp_t resp;
	logic      flush;

	// expected register contents, x0 stays zero
	logic [63:0] shadow [32];
	integer      seed;

	mul_core_top #(.xlen(xlen), .addr_w(reg_addr_w)) DUT (
		.clk(clk), .rst(rst), .req(req), .cmd(cmd), .ack(ack), .resp(resp), .flush(flush)
	);

	always #2 clk = ~clk;

	// ********************
	// helpers
	// ********************

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else
			stop_on_error($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	function automatic mul_cmd_t build_cmd(input mul_op_e op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [63:0] imm);
		mul_cmd_t c;
		c.op  = op;
		c.rd  = rd;
		c.rs1 = rs1;
		c.rs2 = rs2;
		c.imm = imm;
		return c;
	endfunction

	// RV64M rules on a 128-bit product
	function automatic logic [63:0] ref_mul(input mul_op_e op, input logic [63:0] a,
		input logic [63:0] b);
		logic signed [127:0] sa;
		logic signed [127:0] sb;
		logic [127:0]        ua;
		logic [127:0]        ub;
		logic [127:0]        prod;
		logic [31:0]         w;
		ua   = {64'b0, a};
		ub   = {64'b0, b};
		sa   = $signed({{64{a[63]}}, a});
		sb   = $signed({{64{b[63]}}, b});
		prod = '0;
		// low word only, product kept to 32 bits
		w    = a[31:0] * b[31:0];
		case (op)
			op_mulh:   prod = sa * sb;
			// ub has a zero top half so it stays positive
			op_mulhsu: prod = sa * $signed(ub);
			default:   prod = ua * ub;
		endcase
		case (op)
			op_mul:  return prod[63:0];
			op_mulw: return {{32{w[31]}}, w};
			default: return prod[127:64];
		endcase
	endfunction

	// ********************
	// four-phase handshake
	// ********************

	// flush_at: loop count at which flush is pulsed, -1 for none
	task automatic run_txn(input mul_cmd_t c, input int flush_at, output mul_resp_t r,
		output int lat);
		int cnt;
		// previous handshake must be closed
		@(negedge clk);
		assert (!ack) else stop_on_error("ack was still high before a new request");
		@(posedge clk);
		req <= 1'b1;
		cmd <= c;
		cnt = 0;
		@(negedge clk);
		while (!ack) begin
			assert (cnt < ack_timeout) else stop_on_error("timed out waiting for ack to rise");
			@(posedge clk);
			flush <= (cnt == flush_at);
			cnt++;
			@(negedge clk);
		end
		// resp is stable while ack is high
		r   = resp;
		lat = cnt;
		@(posedge clk);
		req   <= 1'b0;
		flush <= 1'b0;
		// ack has to follow req down
		cnt = 0;
		@(negedge clk);
		while (ack) begin
			assert (cnt < ack_timeout) else
				stop_on_error("timed out waiting for ack to fall after req dropped");
			@(negedge clk);
			cnt++;
		end
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [63:0] val);
		mul_resp_t r;
		int        lat;
		run_txn(build_cmd(op_li, rd, 5'd0, 5'd0, val), -1, r, lat);
		check_eq("li resp.data", r.data, val);
		check_eq("li resp.flushed", 64'(r.flushed), 64'h0);
		check_eq("li ack latency", 64'(lat), 64'd3);
		if (rd != 5'd0) begin
			shadow[rd] = val;
		end
	endtask

	task automatic read_check(input logic [4:0] rs);
		mul_resp_t r;
		int        lat;
		run_txn(build_cmd(op_rd, 5'd0, rs, 5'd0, 64'h0), -1, r, lat);
		check_eq($sformatf("rd x%0d resp.data", rs), r.data, shadow[rs]);
		check_eq("rd ack latency", 64'(lat), 64'd3);
	endtask

	// one multiply, then the result is read back from rd
	task automatic mul_check(input mul_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		mul_resp_t   r;
		int          lat;
		logic [63:0] exp;
		exp = ref_mul(op, shadow[rs1], shadow[rs2]);
		run_txn(build_cmd(op, rd, rs1, rs2, 64'h0), -1, r, lat);
		check_eq($sformatf("%s resp.data", op.name()), r.data, exp);
		check_eq($sformatf("%s resp.flushed", op.name()), 64'(r.flushed), 64'h0);
		if (rd != 5'd0) begin
			shadow[rd] = exp;
		end
		read_check(rd);
	endtask

	task automatic pulse_flush();
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	// ********************
	// directed tests
	// ********************

	task automatic load_and_read_back();
		for (int i = 1; i < 9; i++) begin
			load_reg(5'(i), {32'hc0de_0000 | 32'(i), ~32'(i * 32'h0101_0101)});
		end
		for (int i = 1; i < 9; i++) begin
			read_check(5'(i));
		end
		// x0 swallows the write
		load_reg(5'd0, 64'hffff_ffff_ffff_ffff);
		read_check(5'd0);
		// overwrite one and check the neighbour is untouched
		load_reg(5'd3, 64'h1357_9bdf_2468_ace0);
		read_check(5'd3);
		read_check(5'd4);
	endtask

	task automatic corner_multiplies();
		logic [63:0] corner [4];
		mul_op_e     ops [4];
		corner = '{64'h0, 64'h1, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};
		ops    = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
		for (int i = 0; i < 4; i++) begin
			load_reg(5'(i + 1), corner[i]);
		end
		// every pair, including all ones by all ones
		for (int k = 0; k < 4; k++) begin
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++) begin
					mul_check(ops[k], 5'd10, 5'(i + 1), 5'(j + 1));
				end
			end
		end
	endtask

	task automatic word_multiply();
		// junk in the upper halves must be ignored
		load_reg(5'd5, 64'hdead_beef_8000_0003);
		load_reg(5'd6, 64'h1234_5678_7fff_fffd);
		load_reg(5'd7, 64'hffff_ffff_0000_0002);
		load_reg(5'd8, 64'h0000_0001_4000_0000);
		mul_check(op_mulw, 5'd11, 5'd5, 5'd6);
		// low word product is 0x80000000, so the result goes negative
		mul_check(op_mulw, 5'd11, 5'd7, 5'd8);
		mul_check(op_mulw, 5'd11, 5'd6, 5'd6);
	endtask

	task automatic random_sweep();
		int unsigned pick;
		mul_op_e     op;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		for (int i = 1; i < 32; i++) begin
			load_reg(5'(i), {$random(seed), $random(seed)});
		end
		for (int i = 0; i < 40; i++) begin
			pick = $unsigned($random(seed)) % 5;
			op   = mul_op_e'(int'(op_mul) + pick);
			rd   = 5'($unsigned($random(seed)));
			rs1  = 5'($unsigned($random(seed)));
			rs2  = 5'($unsigned($random(seed)));
			// aliasing cases now and then
			if (i % 8 == 3) begin
				rd = rs1;
			end
			if (i % 8 == 5) begin
				rd = 5'd0;
			end
			mul_check(op, rd, rs1, rs2);
		end
	endtask

	task automatic flush_cases();
		mul_resp_t r;
		int        lat;
		load_reg(5'd12, 64'h0bad_cafe_0000_1111);
		load_reg(5'd13, 64'hfedc_ba98_7654_3210);
		load_reg(5'd14, 64'h8765_4321_0fed_cba9);
		// mid-run, multiplier already busy
		run_txn(build_cmd(op_mulhu, 5'd12, 5'd13, 5'd14, 64'h0), 6, r, lat);
		check_eq("flush in wait resp.flushed", 64'(r.flushed), 64'h1);
		check_eq("flush in wait resp.data", r.data, 64'h0);
		read_check(5'd12);
		// just before the multiplier accepts
		run_txn(build_cmd(op_mul, 5'd12, 5'd13, 5'd14, 64'h0), 1, r, lat);
		check_eq("flush in issue resp.flushed", 64'(r.flushed), 64'h1);
		check_eq("flush in issue resp.data", r.data, 64'h0);
		read_check(5'd12);
		// idle flush leaves the next command alone
		pulse_flush();
		mul_check(op_mulh, 5'd12, 5'd13, 5'd14);
		pulse_flush();
		load_reg(5'd15, 64'h0f0f_0f0f_f0f0_f0f0);
		read_check(5'd15);
	endtask

	// ********************
	// main sequence
	// ********************

	initial begin
		clk   = 1'b0;
		rst   = 1'b1;
		req   = 1'b0;
		cmd   = '0;
		flush = 1'b0;
		seed  = 32'hc45c;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		load_and_read_back();
		corner_multiplies();
		word_multiply();
		random_sweep();
		flush_cases();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- hdl/mul_core_top.sv
`timescale 1ns/1ps

module mul_core_top #(
	parameter int xlen   = mul_pkg::xlen_default,
	parameter int addr_w = mul_pkg::reg_addr_w
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	input  mul_pkg::mul_cmd_t  cmd,
	output logic               ack,
	output mul_pkg::mul_resp_t resp,
	input  logic               flush
);

	import mul_pkg::*;

	// ********************
	// register file wires
	// ********************
	logic [addr_w-1:0] rs1_addr;
	logic [addr_w-1:0] rs2_addr;
	logic [xlen-1:0]   rs1_data;
	logic [xlen-1:0]   rs2_data;
	logic              wen;
	logic [addr_w-1:0] waddr;
	logic [xlen-1:0]   wdata;

	// ********************
	// multiplier wires
	// ********************
	logic          mul_valid;
	logic          mul_ready;
	logic          out_valid;
	mul_operands_t operands;
	mul_result_t   result;

	// command FSM
	mul_sequencer #(.xlen(xlen)) u_seq (
		.clk(clk), .rst(rst), .req(req), .cmd(cmd), .ack(ack), .resp(resp), .flush(flush),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.mul_valid(mul_valid), .mul_ready(mul_ready), .operands(operands),
		.out_valid(out_valid), .result(result)
	);

	// gpr, x0 handled inside
	register_file #(.addr_w(addr_w), .width(xlen)) u_gpr (
		.clk(clk), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wen(wen), .waddr(waddr), .wdata(wdata)
	);

	// radix-4 booth unit
	booth_multiplier #(.xlen(xlen)) u_mul (
		.clk(clk), .rst(rst), .mul_valid(mul_valid), .flush(flush), .operands(operands),
		.mul_ready(mul_ready), .out_valid(out_valid), .result(result)
	);

endmodule

//--- hdl/mul_sequencer.sv
`timescale 1ns/1ps

module mul_sequencer #(
	parameter int xlen = 64
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              req,
	input  mul_pkg::mul_cmd_t                 cmd,
	output logic                              ack,
	output mul_pkg::mul_resp_t                resp,
	input  logic                              flush,
	output logic [mul_pkg::reg_addr_w-1:0]    rs1_addr,
	output logic [mul_pkg::reg_addr_w-1:0]    rs2_addr,
	input  logic [xlen-1:0]                   rs1_data,
	input  logic [xlen-1:0]                   rs2_data,
	output logic                              wen,
	output logic [mul_pkg::reg_addr_w-1:0]    waddr,
	output logic [xlen-1:0]                   wdata,
	output logic                              mul_valid,
	input  logic                              mul_ready,
	output mul_pkg::mul_operands_t            operands,
	input  logic                              out_valid,
	input  mul_pkg::mul_result_t              result
);

	import mul_pkg::*;

	seq_state_e state;
	seq_state_e state_nx;

	// latched command and write-back value
	mul_cmd_t        cmd_q;
	logic [xlen-1:0] wb_q;
	logic            flushed_q;
	logic            is_mul;
	logic            flush_hit;
	logic [xlen-1:0] sel_result;

	assign is_mul = (cmd_q.op != op_li) && (cmd_q.op != op_rd);
	// flush only counts before the write-back
	assign flush_hit = flush && ((state == st_read) || (state == st_issue) || (state == st_wait));

	// ********************
	// result select
	// ********************

	always_comb begin
		case (cmd_q.op)
			op_mul:  sel_result = result.lo[xlen-1:0];
			// low word, sign-extended
			op_mulw: sel_result = {{(xlen - 32){result.lo[31]}}, result.lo[31:0]};
			// mulh, mulhsu, mulhu
			default: sel_result = result.hi[xlen-1:0];
		endcase
	end

	// ********************
	// FSM
	// ********************

	always_comb begin
		state_nx = state;
		case (state)
			st_idle:  if (req) state_nx = st_read;
			st_read:  state_nx = is_mul ? st_issue : st_write;
			st_issue: if (mul_ready) state_nx = st_wait;
			st_wait:  if (out_valid) state_nx = st_write;
			st_write: state_nx = st_ack;
			// hold ack until the requester lets go
			st_ack:   if (!req) state_nx = st_idle;
			default:  state_nx = st_idle;
		endcase
		if (flush_hit) begin
			state_nx = st_ack;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_idle;
			flushed_q <= 1'b0;
		end else begin
			state <= state_nx;
			if (state == st_idle && req) begin
				flushed_q <= 1'b0;
			end else if (flush_hit) begin
				flushed_q <= 1'b1;
			end
		end
	end

	// payload regs
	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				if (req) begin
					cmd_q <= cmd;
				end
			end
			st_read: begin
				operands.word         <= (cmd_q.op == op_mulw);
				operands.multiplicand <= rs1_data;
				operands.multiplier   <= rs2_data;
				// signs per opcode, mul/mulhu stay unsigned
				operands.sign_a <= (cmd_q.op == op_mulh) || (cmd_q.op == op_mulhsu);
				operands.sign_b <= (cmd_q.op == op_mulh);
				if (cmd_q.op == op_li) begin
					wb_q <= cmd_q.imm[xlen-1:0];
				end else begin
					// op_rd returns rs1
					wb_q <= rs1_data;
				end
			end
			st_wait: begin
				if (out_valid) begin
					wb_q <= sel_result;
				end
			end
			default: begin
			end
		endcase
		// flushed response carries zero
		if (flush_hit) begin
			wb_q <= '0;
		end
	end

	// ********************
	// outputs
	// ********************

	assign rs1_addr  = cmd_q.rs1;
	assign rs2_addr  = cmd_q.rs2;
	assign mul_valid = (state == st_issue);

	// op_rd passes through st_write without writing
	assign wen   = (state == st_write) && (cmd_q.op != op_rd);
	assign waddr = cmd_q.rd;
	assign wdata = wb_q;

	assign ack          = (state == st_ack);
	assign resp.data    = wb_q;
	assign resp.flushed = flushed_q;

	a_ack_needs_req : assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> req);

	// a write only happens inside an open handshake
	a_wen_in_cmd : assert property (@(posedge clk) disable iff (rst)
		wen |-> (req && !ack));

endmodule

//--- hdl/booth_multiplier.sv
`timescale 1ns/1ps

module booth_multiplier #(
	parameter int xlen = 64
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mul_valid,
	input  logic                   flush,
	input  mul_pkg::mul_operands_t operands,
	output logic                   mul_ready,
	output logic                   out_valid,
	output mul_pkg::mul_result_t   result
);

	import mul_pkg::*;

	// mulw only looks at the low word
	localparam int word_w = 32;
	localparam int cnt_w  = $clog2(xlen / 2);
	// number of radix-4 steps minus one
	localparam logic [cnt_w-1:0] last_full = cnt_w'(xlen / 2 - 1);
	localparam logic [cnt_w-1:0] last_word = cnt_w'(word_w / 2 - 1);

	typedef enum logic [1:0] {
		ms_idle,
		ms_busy,
		ms_done
	} mstate_e;

	mstate_e state;

	// product accumulator kept mod 2^(2*xlen)
	logic [2*xlen-1:0] acc_q;
	// pre-extended multiplicand moves left two bits per step
	logic [2*xlen-1:0] mcand_q;
	// multiplier with two extension bits on top and the implicit zero below
	logic [xlen+2:0]   mulr_q;
	logic [cnt_w-1:0]  cnt_q;
	logic [cnt_w-1:0]  last_q;

	logic [xlen-1:0]   a_src;
	logic [xlen-1:0]   b_src;
	logic              a_sx;
	logic              b_sx;
	logic              accept;
	logic              last_step;
	logic [2*xlen-1:0] term_lo;
	logic [2*xlen-1:0] term_hi;
	logic [2*xlen-1:0] acc_nx;

	// booth recoding of one group of three bits
	function automatic logic [2*xlen-1:0] booth_term(input logic [2:0] grp,
		input logic [2*xlen-1:0] mc);
		logic [2*xlen-1:0] t;
		case (grp)
			3'b001, 3'b010: t = mc;
			3'b011:         t = mc << 1;
			3'b100:         t = ~(mc << 1) + 1'b1;
			3'b101, 3'b110: t = ~mc + 1'b1;
			// 000 and 111
			default:        t = '0;
		endcase
		return t;
	endfunction

	// ********************
	// operand prep
	// ********************

	// word mode sign-extends the low word of each operand
	always_comb begin
		if (operands.word) begin
			a_src = {{(xlen - word_w){operands.multiplicand[word_w-1]}},
				operands.multiplicand[word_w-1:0]};
			b_src = {{(xlen - word_w){operands.multiplier[word_w-1]}},
				operands.multiplier[word_w-1:0]};
		end else begin
			a_src = operands.multiplicand[xlen-1:0];
			b_src = operands.multiplier[xlen-1:0];
		end
	end

	// extra top bit comes from the sign flag (always signed in word mode)
	assign a_sx = (operands.sign_a | operands.word) & a_src[xlen-1];
	assign b_sx = (operands.sign_b | operands.word) & b_src[xlen-1];

	assign accept = mul_valid && mul_ready && !flush;

	// ********************
	// datapath step
	// ********************

	assign last_step = (cnt_q == last_q);

	// current group from the low three bits
	assign term_lo = booth_term(mulr_q[2:0], mcand_q);
	// one group past the end is only nonzero for an unsigned top bit
	assign term_hi = booth_term(mulr_q[4:2], mcand_q << 2);

	always_comb begin
		acc_nx = acc_q + term_lo;
		if (last_step) begin
			acc_nx = acc_nx + term_hi;
		end
	end

	// payload regs
	always_ff @(posedge clk) begin
		if (accept) begin
			acc_q   <= '0;
			mcand_q <= {{xlen{a_sx}}, a_src};
			mulr_q  <= {b_sx, b_sx, b_src, 1'b0};
			last_q  <= operands.word ? last_word : last_full;
		end else if (state == ms_busy) begin
			acc_q   <= acc_nx;
			mcand_q <= mcand_q << 2;
			mulr_q  <= mulr_q >> 2;
		end
	end

	// ********************
	// control
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ms_idle;
			cnt_q <= '0;
		end else if (flush) begin
			// drop whatever is running
			state <= ms_idle;
			cnt_q <= '0;
		end else begin
			case (state)
				ms_idle: begin
					cnt_q <= '0;
					if (accept) begin
						state <= ms_busy;
					end
				end
				ms_busy: begin
					cnt_q <= cnt_q + 1'b1;
					if (last_step) begin
						state <= ms_done;
					end
				end
				default: begin
					state <= ms_idle;
				end
			endcase
		end
	end

	assign mul_ready = (state == ms_idle);
	// a flush in the done cycle still swallows the result
	assign out_valid = (state == ms_done) && !flush;

	assign result.hi = acc_q[2*xlen-1:xlen];
	assign result.lo = acc_q[xlen-1:0];

	// the sequencer holds off while a run is in progress
	a_no_valid_busy : assert property (@(posedge clk) disable iff (rst)
		(state == ms_busy) |-> !mul_valid);

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file #(
	parameter int addr_w = 5,
	parameter int width  = 64
) (
	input  logic              clk,
	input  logic [addr_w-1:0] rs1_addr,
	input  logic [addr_w-1:0] rs2_addr,
	output logic [width-1:0]  rs1_data,
	output logic [width-1:0]  rs2_data,
	input  logic              wen,
	input  logic [addr_w-1:0] waddr,
	input  logic [width-1:0]  wdata
);

	// register storage
	logic [width-1:0] regs [2**addr_w];

	// ********************
	// write port
	// ********************

	// x0 is hardwired to zero and drops its writes
	always_ff @(posedge clk) begin
		if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// ********************
	// read ports
	// ********************

	// combinational reads
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hdl/mul_pkg.sv
package mul_pkg;

	// ********************
	// widths
	// ********************

	// core data width, the top level starts from this
	localparam int xlen_default = 64;
	// 32 general registers
	localparam int reg_addr_w = 5;

	// ********************
	// command side
	// ********************

	// li/rd are register housekeeping, the rest are RV64M multiplies
	typedef enum logic [2:0] {
		op_li     = 3'd0,
		op_rd     = 3'd1,
		op_mul    = 3'd2,
		op_mulh   = 3'd3,
		op_mulhsu = 3'd4,
		op_mulhu  = 3'd5,
		op_mulw   = 3'd6
	} mul_op_e;

	typedef struct packed {
		mul_op_e               op;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [63:0]           imm;
	} mul_cmd_t;

	// data is zero when flushed is set
	typedef struct packed {
		logic [63:0] data;
		logic        flushed;
	} mul_resp_t;

	// ********************
	// multiplier side
	// ********************

	// word selects the mulw path, sign_* mark signed operands
	typedef struct packed {
		logic        word;
		logic        sign_a;
		logic        sign_b;
		logic [63:0] multiplicand;
		logic [63:0] multiplier;
	} mul_operands_t;

	typedef struct packed {
		logic [63:0] hi;
		logic [63:0] lo;
	} mul_result_t;

	// sequencer states
	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_issue,
		st_wait,
		st_write,
		st_ack
	} seq_state_e;

endpackage
